//--- src/hba_cfg.svh
// HBA bus geometry, GPIO peripheral number and pin count macros
`ifndef HBA_CFG_SVH
`define HBA_CFG_SVH

// Data bus width in bits
`define HBA_DBUS_WIDTH 8

// Upper address field picks the peripheral
`define HBA_PERIPH_ADDR_WIDTH 4

// Lower address field picks a register inside the peripheral
`define HBA_REG_ADDR_WIDTH 8

// Full address, peripheral field on top
`define HBA_ADDR_WIDTH (`HBA_PERIPH_ADDR_WIDTH + `HBA_REG_ADDR_WIDTH)

// Peripheral number of the GPIO block
`define HBA_GPIO_PERIPH_ADDR 2

// Number of GPIO pins handled
`define HBA_GPIO_PINS 4

`endif

//--- src/hba_pkg.sv
// Shared HBA types: vector widths, bus request/response structs,
// register bank FSM states
`include "hba_cfg.svh"

package hba_pkg;

    // Vectors with a meaning on the bus
    typedef logic [`HBA_DBUS_WIDTH-1:0] hba_data_t;  // One data word
    typedef logic [`HBA_ADDR_WIDTH-1:0] hba_addr_t;  // Periph field + reg field
    typedef logic [`HBA_GPIO_PINS-1:0]  gpio_vec_t;  // One bit per pin

    // Master to slave, held stable until xferack
    typedef struct packed {
        logic      rnw;     // 1 = read, 0 = write
        logic      select;  // Transfer in progress
        hba_addr_t abus;    // Target address
        hba_data_t dbus;    // Write data
    } hba_bus_req_t;

    // Slave to master, all zero when idle
    typedef struct packed {
        hba_data_t dbus_slave;  // Read data, valid with xferack
        logic      xferack;     // One cycle transfer acknowledge
    } hba_bus_rsp_t;

    // Register bank ack machine
    typedef enum logic [1:0] {
        BANK_IDLE    = 2'd0,  // Waiting for a matching select
        BANK_ACK     = 2'd1,  // xferack high this cycle
        BANK_RELEASE = 2'd2   // Hold off until select drops
    } hba_bank_state_t;

endpackage

//--- src/hba_pin_sync.sv
// Two-flop synchronizer for the GPIO input pins

module hba_pin_sync (
    input  logic               hba_clk,
    input  logic               hba_reset,
    input  hba_pkg::gpio_vec_t pins_async,  // Straight from the pads
    output hba_pkg::gpio_vec_t pins_sync    // Safe to use in hba_clk domain
);

    hba_pkg::gpio_vec_t meta;  // First stage, may go metastable

    // Stage 1 catches the pad level, stage 2 settles it
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            meta      <= '0;
            pins_sync <= '0;
        end else begin
            meta      <= pins_async;
            pins_sync <= meta;  // Two edges of latency
        end
    end

endmodule

//--- src/hba_reg_bank.sv
// HBA bus slave register bank: address decode, ack FSM, three registers
// with a masked internal write port and the read mux
`include "hba_cfg.svh"

module hba_reg_bank #(
    parameter int PERIPH_ADDR = 0  // This slave's peripheral number
) (
    input  logic                  hba_clk,
    input  logic                  hba_reset,
    input  hba_pkg::hba_bus_req_t bus_req,      // From the master
    output hba_pkg::hba_bus_rsp_t bus_rsp,      // Back to the master
    output hba_pkg::hba_data_t    reg_dir,      // Reg 0, 1 = output
    output hba_pkg::hba_data_t    reg_pins,     // Reg 1, pin levels
    output hba_pkg::hba_data_t    reg_intr_en,  // Reg 2, change irq enables
    input  hba_pkg::hba_data_t    pins_next,    // Internal write value
    input  logic                  int_wr_en,    // Internal write strobe
    input  logic [2:0]            int_wr_mask   // Regs open to internal writes
);

    localparam int NUM_REGS = 3;
    // Peripheral number cut to the field width
    localparam logic [`HBA_PERIPH_ADDR_WIDTH-1:0] PERIPH_SEL =
        `HBA_PERIPH_ADDR_WIDTH'(PERIPH_ADDR);

    logic [`HBA_PERIPH_ADDR_WIDTH-1:0] periph_field;  // Upper address bits
    logic [`HBA_REG_ADDR_WIDTH-1:0]    reg_idx;       // Lower address bits
    hba_pkg::hba_bank_state_t          state;
    hba_pkg::hba_data_t                regs [NUM_REGS];
    hba_pkg::hba_data_t                rd_data;       // Read mux output
    logic                              hit;           // New request for us
    logic                              bus_wr;        // Bus write this edge

    // Address split
    assign periph_field = bus_req.abus[`HBA_ADDR_WIDTH-1:`HBA_REG_ADDR_WIDTH];
    assign reg_idx      = bus_req.abus[`HBA_REG_ADDR_WIDTH-1:0];

    // Only a fresh select in IDLE counts, so no double ack
    assign hit    = (state == hba_pkg::BANK_IDLE) && bus_req.select &&
                    (periph_field == PERIPH_SEL);
    assign bus_wr = hit && !bus_req.rnw;

    // Read mux
    always_comb begin
        rd_data = '0;  // Index 3 and up read zero
        for (int i = 0; i < NUM_REGS; i++) begin
            if (reg_idx == `HBA_REG_ADDR_WIDTH'(i)) begin
                rd_data = regs[i];
            end
        end
    end

    // Ack FSM and registered response
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state   <= hba_pkg::BANK_IDLE;
            bus_rsp <= '0;
        end else begin
            bus_rsp <= '0;  // Default: bus idle, response zero
            case (state)
                hba_pkg::BANK_IDLE: begin
                    if (hit) begin
                        state           <= hba_pkg::BANK_ACK;
                        bus_rsp.xferack <= 1'b1;  // One edge after select
                        if (bus_req.rnw) begin
                            bus_rsp.dbus_slave <= rd_data;
                        end
                    end
                end
                hba_pkg::BANK_ACK: begin
                    // Master may already have dropped select
                    if (bus_req.select) begin
                        state <= hba_pkg::BANK_RELEASE;
                    end else begin
                        state <= hba_pkg::BANK_IDLE;
                    end
                end
                hba_pkg::BANK_RELEASE: begin
                    if (!bus_req.select) begin
                        state <= hba_pkg::BANK_IDLE;  // Request retired
                    end
                end
                default: state <= hba_pkg::BANK_IDLE;
            endcase
        end
    end

    // Register storage
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (bus_wr && reg_idx == `HBA_REG_ADDR_WIDTH'(i)) begin
                    regs[i] <= bus_req.dbus;  // Bus wins over core
                end else if (int_wr_en && int_wr_mask[i]) begin
                    regs[i] <= pins_next;     // Core update
                end
            end
        end
    end

    assign reg_dir     = regs[0];
    assign reg_pins    = regs[1];
    assign reg_intr_en = regs[2];

    // One ack per request, never two in a row
    a_ack_one_cycle: assert property (
        @(posedge hba_clk) disable iff (hba_reset)
        bus_rsp.xferack |=> !bus_rsp.xferack
    ) else $error("xferack high on two consecutive cycles");

    // Ack only while the master still holds select
    a_ack_with_select: assert property (
        @(posedge hba_clk) disable iff (hba_reset)
        bus_rsp.xferack |-> bus_req.select
    ) else $error("xferack without select");

endmodule

//--- src/hba_gpio.sv
// GPIO core: register bank, pin drivers, input capture into the pins
// register and the pin change interrupt
`include "hba_cfg.svh"

module hba_gpio #(
    parameter int PERIPH_ADDR = 0  // Peripheral number on the bus
) (
    input  logic                  hba_clk,
    input  logic                  hba_reset,
    input  hba_pkg::hba_bus_req_t bus_req,
    output hba_pkg::hba_bus_rsp_t bus_rsp,
    output logic                  irq,           // One cycle change pulse
    output hba_pkg::gpio_vec_t    gpio_out_en,   // 1 = pin driven
    output hba_pkg::gpio_vec_t    gpio_out_sig,  // Driven level
    input  hba_pkg::gpio_vec_t    pins_in        // Synchronized pad levels
);

    localparam int PINS = `HBA_GPIO_PINS;
    localparam logic [2:0] WR_MASK = 3'b010;  // Only reg 1 takes core writes

    hba_pkg::hba_data_t reg_dir;
    hba_pkg::hba_data_t reg_pins;
    hba_pkg::hba_data_t reg_intr_en;
    hba_pkg::hba_data_t pins_next;   // Word offered to the bank
    hba_pkg::gpio_vec_t in_val_q;    // Sampled inputs, zero on outputs
    hba_pkg::gpio_vec_t in_mask_q;   // Which pins were inputs at sampling
    logic               in_wr_q;     // Any input pin, core write strobe
    hba_pkg::gpio_vec_t pins_prev;   // Pins reg one cycle back

    hba_reg_bank #(
        .PERIPH_ADDR(PERIPH_ADDR)
    ) u_reg_bank (
        .hba_clk    (hba_clk),
        .hba_reset  (hba_reset),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .reg_dir    (reg_dir),
        .reg_pins   (reg_pins),
        .reg_intr_en(reg_intr_en),
        .pins_next  (pins_next),
        .int_wr_en  (in_wr_q),
        .int_wr_mask(WR_MASK)
    );

    // Pin drivers, one edge behind the registers
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            gpio_out_en  <= '0;
            gpio_out_sig <= '0;
        end else begin
            gpio_out_en  <= reg_dir[PINS-1:0];
            gpio_out_sig <= reg_pins[PINS-1:0];
        end
    end

    // Sample levels of pins currently set as inputs
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            in_val_q  <= '0;
            in_mask_q <= '0;
            in_wr_q   <= 1'b0;
        end else begin
            in_mask_q <= ~gpio_out_en;
            in_val_q  <= pins_in & ~gpio_out_en;  // Drop output pins
            in_wr_q   <= |(~gpio_out_en);         // Strobe if any input
        end
    end

    // Merge: output bits keep the live register value so a bus write
    // to an output pin is never undone by the core
    always_comb begin
        pins_next           = reg_pins;
        pins_next[PINS-1:0] = (reg_pins[PINS-1:0] & ~in_mask_q) | in_val_q;
    end

    // Change detect under the enable mask
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            pins_prev <= '0;
            irq       <= 1'b0;
        end else begin
            irq       <= |((reg_pins[PINS-1:0] ^ pins_prev) & reg_intr_en[PINS-1:0]);
            pins_prev <= reg_pins[PINS-1:0];  // Remember for next compare
        end
    end

    // No pulse can start without some enable bit set the cycle before
    a_irq_needs_enable: assert property (
        @(posedge hba_clk) disable iff (hba_reset)
        $rose(irq) |-> $past(|reg_intr_en[PINS-1:0])
    ) else $error("irq rose with all interrupt enables clear");

endmodule

//--- src/hba_gpio_top.sv
// GPIO peripheral top: input synchronizer beside the GPIO core
`include "hba_cfg.svh"

module hba_gpio_top (
    input  logic                  hba_clk,
    input  logic                  hba_reset,
    input  hba_pkg::hba_bus_req_t bus_req,       // From the bus master
    output hba_pkg::hba_bus_rsp_t bus_rsp,       // Slave response
    output logic                  irq,           // Pin change pulse
    output hba_pkg::gpio_vec_t    gpio_out_en,   // Per pin output enable
    output hba_pkg::gpio_vec_t    gpio_out_sig,  // Per pin output level
    input  hba_pkg::gpio_vec_t    gpio_in_sig    // Raw pad inputs
);

    hba_pkg::gpio_vec_t pins_sync;  // Inputs in the hba_clk domain

    hba_pin_sync u_pin_sync (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset),
        .pins_async(gpio_in_sig),
        .pins_sync (pins_sync)
    );

    hba_gpio #(
        .PERIPH_ADDR(`HBA_GPIO_PERIPH_ADDR)
    ) u_gpio (
        .hba_clk     (hba_clk),
        .hba_reset   (hba_reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .irq         (irq),
        .gpio_out_en (gpio_out_en),
        .gpio_out_sig(gpio_out_sig),
        .pins_in     (pins_sync)
    );

endmodule

//--- tests/tb_hba_gpio_top.sv
// Testbench for hba_gpio_top: table of bus and pin steps, shadow register
// model, irq pulse counter, LFSR pin stretch and a cycle timeout
`include "hba_cfg.svh"

module tb_hba_gpio_top;

    localparam int PERIPH       = `HBA_GPIO_PERIPH_ADDR;
    localparam int PINS         = `HBA_GPIO_PINS;
    localparam int RESET_CYCLES = 4;
    localparam int ACK_LIMIT    = 4;   // Cycles allowed for xferack
    localparam int PIN_WAIT     = 6;   // Sync path plus irq, with margin
    localparam int RAND_STEPS   = 20;
    localparam logic [31:0] LFSR_SEED = 32'd70713;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

    typedef enum logic [1:0] {
        OP_WRITE,  // Bus write
        OP_READ,   // Bus read, compare data
        OP_PINS,   // Set input pins, wait, compare irq count and outputs
        OP_MISS    // Request to another peripheral, no ack expected
    } op_t;

    typedef struct packed {
        op_t                op;
        hba_pkg::hba_addr_t addr;
        hba_pkg::hba_data_t data;
        hba_pkg::gpio_vec_t pins;
        hba_pkg::hba_data_t exp_data;
        logic [7:0]         exp_irqs;  // Running total, checked on OP_PINS
    } entry_t;

    logic                  hba_clk;
    logic                  hba_reset;
    hba_pkg::hba_bus_req_t bus_req;
    hba_pkg::hba_bus_rsp_t bus_rsp;
    logic                  irq;
    hba_pkg::gpio_vec_t    gpio_out_en;
    hba_pkg::gpio_vec_t    gpio_out_sig;
    hba_pkg::gpio_vec_t    gpio_in_sig;

    entry_t             table_q[$];
    hba_pkg::hba_data_t sh_dir;        // Shadow registers
    hba_pkg::hba_data_t sh_pins;
    hba_pkg::hba_data_t sh_en;
    hba_pkg::gpio_vec_t pin_level;     // Level now on the input pins
    logic [31:0]        lfsr;
    int                 irq_count = 0;
    int                 cycle_count = 0;
    int                 timeout_limit = 0;
    int                 fail_count = 0;

    hba_gpio_top uut (
        .hba_clk     (hba_clk),
        .hba_reset   (hba_reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .irq         (irq),
        .gpio_out_en (gpio_out_en),
        .gpio_out_sig(gpio_out_sig),
        .gpio_in_sig (gpio_in_sig)
    );

    initial hba_clk = 1'b0;
    always #10 hba_clk = ~hba_clk;  // 20 unit period

    // Pulses counted mid cycle, away from the edge
    always @(negedge hba_clk) begin
        if (!hba_reset && irq) begin
            irq_count++;
        end
    end

    always @(posedge hba_clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            report_failure($sformatf("timeout: run passed %0d cycles", timeout_limit));
        end
    end

    task automatic report_failure(input string what);
        fail_count++;
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) else begin
            report_failure($sformatf("mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                                     $time, name, exp, got));
        end
    endtask

    // Advance n edges, then sit 1 unit past the last one
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge hba_clk);
        #1;
    endtask

    function automatic hba_pkg::hba_addr_t make_addr(input int periph, input int idx);
        return {`HBA_PERIPH_ADDR_WIDTH'(periph), `HBA_REG_ADDR_WIDTH'(idx)};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic void add_entry(input op_t op, input int periph, input int idx,
                                      input int data, input int pins, input int exp_data,
                                      input int exp_irqs);
        entry_t e;
        e.op       = op;
        e.addr     = make_addr(periph, idx);
        e.data     = hba_pkg::hba_data_t'(data);
        e.pins     = hba_pkg::gpio_vec_t'(pins);
        e.exp_data = hba_pkg::hba_data_t'(exp_data);
        e.exp_irqs = 8'(exp_irqs);
        table_q.push_back(e);
    endfunction

    // Input pins overwrite their bits of the pins register
    function automatic void apply_inputs();
        for (int i = 0; i < PINS; i++) begin
            if (!sh_dir[i]) begin
                sh_pins[i] = pin_level[i];
            end
        end
    endfunction

    function automatic void shadow_write(input int idx, input hba_pkg::hba_data_t data);
        case (idx)
            0: sh_dir = data;
            1: sh_pins = data;
            2: sh_en = data;
            default: ;  // Unused indices ignore writes
        endcase
        apply_inputs();
    endfunction

    task automatic bus_transfer(input logic rnw, input hba_pkg::hba_addr_t addr,
                                input hba_pkg::hba_data_t wdata,
                                output hba_pkg::hba_data_t rdata);
        int   waited;
        logic acked;
        bus_req.rnw    = rnw;
        bus_req.select = 1'b1;
        bus_req.abus   = addr;
        bus_req.dbus   = wdata;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < ACK_LIMIT) begin
            wait_cycles(1);
            waited++;
            acked = bus_rsp.xferack;
        end
        assert (acked) else begin
            report_failure($sformatf("no xferack within %0d cycles for address 0x%h",
                                     ACK_LIMIT, addr));
        end
        rdata = bus_rsp.dbus_slave;
        wait_cycles(1);  // Select stays up through the ack cycle
        bus_req = '0;
        wait_cycles(1);
    endtask

    task automatic expect_no_ack(input hba_pkg::hba_addr_t addr,
                                 input hba_pkg::hba_data_t wdata);
        bus_req.rnw    = 1'b0;
        bus_req.select = 1'b1;
        bus_req.abus   = addr;
        bus_req.dbus   = wdata;
        repeat (ACK_LIMIT) begin
            wait_cycles(1);
            assert (!bus_rsp.xferack) else begin
                report_failure($sformatf("xferack for address 0x%h of another peripheral",
                                         addr));
            end
        end
        bus_req = '0;
        wait_cycles(1);
    endtask

    task automatic drive_pins_and_wait(input hba_pkg::gpio_vec_t v);
        gpio_in_sig = v;
        pin_level   = v;
        apply_inputs();
        wait_cycles(PIN_WAIT);
    endtask

    // Output pins only, input pins may show anything on gpio_out_sig
    task automatic check_outputs();
        compare_value("gpio_out_en", 32'(sh_dir[PINS-1:0]), 32'(gpio_out_en));
        compare_value("gpio_out_sig", 32'(sh_pins[PINS-1:0] & sh_dir[PINS-1:0]),
                      32'(gpio_out_sig & sh_dir[PINS-1:0]));
    endtask

    task automatic load_table();
        add_entry(OP_READ,  PERIPH, 0, 'h00, 'h0, 'h00, 0);  // Reset values
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'h00, 0);
        add_entry(OP_READ,  PERIPH, 2, 'h00, 'h0, 'h00, 0);
        add_entry(OP_READ,  PERIPH, 5, 'h00, 'h0, 'h00, 0);  // Unused index
        add_entry(OP_WRITE, PERIPH, 0, 'h0F, 'h0, 'h00, 0);  // All outputs
        add_entry(OP_WRITE, PERIPH, 1, 'hC5, 'h0, 'h00, 0);
        add_entry(OP_READ,  PERIPH, 0, 'h00, 'h0, 'h0F, 0);
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hC5, 0);
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'h0, 'h00, 0);  // Output check
        add_entry(OP_WRITE, PERIPH, 0, 'h03, 'h0, 'h00, 0);  // Pins 2,3 in
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'hC, 'h00, 0);
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hCD, 0);
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'h7, 'h00, 0);  // Outputs ignore pins
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hC5, 0);
        add_entry(OP_WRITE, PERIPH, 2, 'h04, 'h0, 'h00, 0);  // Enable pin 2
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'hB, 'h00, 1);  // Pin 2 falls
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'h3, 'h00, 1);  // Disabled pin 3
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'h4, 'h00, 2);  // Pin 2 rises
        add_entry(OP_WRITE, PERIPH, 2, 'h05, 'h0, 'h00, 2);
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'hE, 'h00, 2);  // Pin 0 is output
        add_entry(OP_WRITE, PERIPH, 1, 'hCC, 'h0, 'h00, 3);  // Output pin 0 falls
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'hC, 'h00, 3);
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hCC, 3);
        add_entry(OP_MISS,  3,      2, 'hFF, 'h0, 'h00, 3);
        add_entry(OP_MISS,  1,      0, 'h00, 'h0, 'h00, 3);
        add_entry(OP_READ,  PERIPH, 0, 'h00, 'h0, 'h03, 3);  // Untouched
        add_entry(OP_READ,  PERIPH, 2, 'h00, 'h0, 'h05, 3);
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hCC, 3);
        add_entry(OP_WRITE, PERIPH, 3, 'h55, 'h0, 'h00, 3);
        add_entry(OP_READ,  PERIPH, 3, 'h00, 'h0, 'h00, 3);
        add_entry(OP_WRITE, PERIPH, 0, 'h00, 'h0, 'h00, 3);  // All inputs
        add_entry(OP_WRITE, PERIPH, 2, 'h0F, 'h0, 'h00, 3);  // All enabled
        add_entry(OP_PINS,  PERIPH, 0, 'h00, 'hC, 'h00, 3);
        add_entry(OP_READ,  PERIPH, 1, 'h00, 'h0, 'hCC, 3);
    endtask

    initial begin
        entry_t             e;
        hba_pkg::hba_data_t rdata;
        hba_pkg::gpio_vec_t rand_val;
        hba_pkg::gpio_vec_t prev_val;
        int                 irq_expected;
        hba_reset   = 1'b1;
        bus_req     = '0;
        gpio_in_sig = '0;
        sh_dir      = '0;
        sh_pins     = '0;
        sh_en       = '0;
        pin_level   = '0;
        lfsr        = LFSR_SEED;
        irq_expected = 0;
        load_table();
        timeout_limit = (table_q.size() + RAND_STEPS) * 12 + 50;

        repeat (RESET_CYCLES) @(posedge hba_clk);
        #1;
        hba_reset = 1'b0;
        compare_value("bus_rsp", 32'd0, 32'(bus_rsp));
        compare_value("irq", 32'd0, 32'(irq));
        compare_value("gpio_out_en", 32'd0, 32'(gpio_out_en));
        compare_value("gpio_out_sig", 32'd0, 32'(gpio_out_sig));

        foreach (table_q[n]) begin
            e = table_q[n];
            case (e.op)
                OP_WRITE: begin
                    bus_transfer(1'b0, e.addr, e.data, rdata);
                    shadow_write(int'(e.addr[`HBA_REG_ADDR_WIDTH-1:0]), e.data);
                end
                OP_READ: begin
                    bus_transfer(1'b1, e.addr, '0, rdata);
                    compare_value("dbus_slave", 32'(e.exp_data), 32'(rdata));
                end
                OP_PINS: begin
                    drive_pins_and_wait(e.pins);
                    irq_expected = int'(e.exp_irqs);
                    compare_value("irq count", 32'(irq_expected), 32'(irq_count));
                    check_outputs();
                end
                OP_MISS: expect_no_ack(e.addr, e.data);
                default: ;
            endcase
        end

        // Random pin stretch, all pins inputs with irq enabled
        prev_val = pin_level;
        for (int k = 0; k < RAND_STEPS; k++) begin
            for (int b = 0; b < PINS; b++) begin
                rand_val[b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            if (((rand_val ^ prev_val) & sh_en[PINS-1:0]) != '0) begin
                irq_expected++;  // One pulse per enabled change
            end
            drive_pins_and_wait(rand_val);
            compare_value("irq count", 32'(irq_expected), 32'(irq_count));
            check_outputs();
            bus_transfer(1'b1, make_addr(PERIPH, 1), '0, rdata);
            compare_value("dbus_slave", 32'(sh_pins), 32'(rdata));
            prev_val = rand_val;
        end

        if (fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure("errors were recorded during the run");
        end
    end

endmodule

//--- filelist.f
+incdir+src
src/hba_pkg.sv
src/hba_pin_sync.sv
src/hba_reg_bank.sv
src/hba_gpio.sv
src/hba_gpio_top.sv
tests/tb_hba_gpio_top.sv

//--- Makefile
# Verilator flow for the HBA GPIO peripheral

VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_hba_gpio_top
RTL_TOP   = hba_gpio_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM_LOG   = sim.log
PASS_MSG  = Test OK

.PHONY: all lint build sim clean

all: sim

# Lint the design top and the testbench top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)

# Pass or fail is taken from the log, not from the exit code
sim: build
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(SIM_LOG)
	@grep -q "$(PASS_MSG)" $(SIM_LOG) && echo "simulation passed" || \
		(echo "simulation did not pass, see $(SIM_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
